// File: src.f
src/pktbuf_pkg.sv
src/qbuf_if.sv
src/word_fifo.sv
src/in_arbiter.sv
src/queue_mem.sv
src/out_arbiter.sv
src/pktbuf_top.sv
verif/pktbuf_checker.sv
verif/pktbuf_tb.sv

// File: run.sh
#!/bin/bash
set -o pipefail
rm -rf obj_dir sim.log
verilator --binary --assert -j 0 -f src.f --top-module pktbuf_tb -o pktbuf_sim \
   && ./obj_dir/pktbuf_sim 2>&1 | tee sim.log \
   || { echo "build or simulation did not complete"; exit 1; }
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

// File: verif/pktbuf_tb.sv
module pktbuf_tb;
   import pktbuf_pkg::*;

   localparam int WORDS_PER_QUEUE = 200;
   localparam int TIMEOUT_CYCLES  = 100 * WORDS_PER_QUEUE;   // ~25x a normal run
   localparam int HOLD_START      = 100;                     // queue 0 output held here
   localparam int HOLD_END        = HOLD_START + 300;
   localparam int FILL_DONE       = HOLD_END - 50;           // queue 0 full well before this
   localparam int MAX_PENDING     = IN_FIFO_DEPTH + QUEUE_DEPTH + OUT_FIFO_DEPTH;
   localparam logic [31:0] SEED   = 32'h97eeda2b;

   logic                              intClk = 1'b0;
   logic                              rst;
   logic [NUM_QUEUES-1:0][DATA_W-1:0] s_axis_tdata;
   logic [NUM_QUEUES-1:0]             s_axis_tlast;
   logic [NUM_QUEUES-1:0]             s_axis_tvalid;
   logic [NUM_QUEUES-1:0]             s_axis_tready;
   logic [NUM_QUEUES-1:0][DATA_W-1:0] m_axis_tdata;
   logic [NUM_QUEUES-1:0]             m_axis_tlast;
   logic [NUM_QUEUES-1:0]             m_axis_tvalid;
   logic [NUM_QUEUES-1:0]             m_axis_tready;
   logic [NUM_QUEUES-1:0][WORD_W-1:0] exp_word;   // next word each output should show
   logic [NUM_QUEUES-1:0]             accept;     // transfer at the coming edge
   logic [31:0]                       lfsr;
   logic                              late_ready;
   int                                rx_cnt [NUM_QUEUES];
   int                                sent [NUM_QUEUES];
   int                                hold_base [NUM_QUEUES];
   int                                check_errors;
   int                                seq_errors;
   int                                cycle;

   always #4 intClk = ~intClk;

   pktbuf_top i_dut (.*);

   pktbuf_checker #(.WORDS_PER_QUEUE(WORDS_PER_QUEUE)) i_checker (
      .clk (intClk), .rst, .s_axis_tready, .m_axis_tdata, .m_axis_tlast, .m_axis_tvalid,
      .m_axis_tready, .exp_word, .rx_cnt, .error_count (check_errors)
   );

   //////////////////////////////
   // random bits and reference
   //////////////////////////////

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic draw_bit();
      lfsr = lfsr_next(lfsr);
      return lfsr[0];
   endfunction

   function automatic logic [WORD_W-1:0] ref_word(input int q, input int n);
      logic [DATA_W-1:0] data;
      logic              last;
      data[31:30] = 2'(q);
      data[29:16] = 14'(n);
      data[15:0]  = 16'(n * 16'h9e37 + q);
      last        = ((n + 1) % (q + 2)) == 0;   // packet length q+2
      return {last, data};
   endfunction

   always_comb
   begin
      for (int q = 0; q < NUM_QUEUES; q++)
         exp_word[q] = ref_word(q, rx_cnt[q]);
   end

   function automatic logic all_delivered();
      logic done;
      done = 1'b1;
      for (int q = 0; q < NUM_QUEUES; q++)
         if (rx_cnt[q] < WORDS_PER_QUEUE)
            done = 1'b0;
      return done;
   endfunction

   // runs 1 unit after the edge, so the DUT outputs read here are settled
   task automatic drive_cycle();
      for (int q = 0; q < NUM_QUEUES; q++)
      begin
         if (accept[q])
            sent[q]++;
         if (!s_axis_tvalid[q] || accept[q])
         begin
            s_axis_tvalid[q] = 1'b0;
            if (sent[q] < WORDS_PER_QUEUE)
               s_axis_tvalid[q] = draw_bit();
            {s_axis_tlast[q], s_axis_tdata[q]} = ref_word(q, sent[q]);
         end
         m_axis_tready[q] = draw_bit();
         if (q == 0 && cycle >= HOLD_START && cycle < HOLD_END)
            m_axis_tready[q] = 1'b0;
         accept[q] = s_axis_tvalid[q] && s_axis_tready[q];
         if (sent[q] - rx_cnt[q] > MAX_PENDING)
         begin
            $display("queue %0d holds more undelivered words than it has room for", q);
            seq_errors++;
         end
      end
   endtask

   task automatic watch_hold();
      if (cycle == HOLD_START)
         for (int q = 1; q < NUM_QUEUES; q++)
            hold_base[q] = rx_cnt[q];
      // region and both FIFOs of queue 0 are full by now
      if (cycle >= FILL_DONE && cycle < HOLD_END && sent[0] < WORDS_PER_QUEUE
          && s_axis_tready[0])
         late_ready = 1'b1;
      if (cycle == HOLD_END)
      begin
         if (late_ready)
         begin
            $display("queue 0 kept accepting input while its output was held");
            seq_errors++;
         end
         for (int q = 1; q < NUM_QUEUES; q++)
            if (rx_cnt[q] == hold_base[q])
            begin
               $display("queue %0d delivered nothing while queue 0 was held", q);
               seq_errors++;
            end
      end
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////

   initial
   begin
      rst           = 1'b1;
      s_axis_tdata  = '0;
      s_axis_tlast  = '0;
      s_axis_tvalid = '0;
      m_axis_tready = '0;
      accept        = '0;
      lfsr          = SEED;
      late_ready    = 1'b0;
      seq_errors    = 0;
      cycle         = 0;
      for (int q = 0; q < NUM_QUEUES; q++)
         sent[q] = 0;
      repeat (3) @(posedge intClk);
      #1 rst = 1'b0;
      while (!all_delivered() && cycle < TIMEOUT_CYCLES)
      begin
         drive_cycle();
         watch_hold();
         @(posedge intClk);
         #1;
         cycle++;
      end
      s_axis_tvalid = '0;
      m_axis_tready = '1;
      repeat (8) @(posedge intClk);   // catch stray extra words
      $display("checker errors: %0d, sequence errors: %0d, cycles: %0d",
               check_errors, seq_errors, cycle);
      if (cycle >= TIMEOUT_CYCLES)
      begin
         $display("timeout: not every queue delivered all of its words in time");
         $display("TESTS FAILED");
      end
      else if (check_errors + seq_errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: verif/pktbuf_checker.sv
module pktbuf_checker #(
   parameter int WORDS_PER_QUEUE = 200
) (
   input  logic                                                      clk,
   input  logic                                                      rst,
   input  logic [pktbuf_pkg::NUM_QUEUES-1:0]                         s_axis_tready,
   input  logic [pktbuf_pkg::NUM_QUEUES-1:0][pktbuf_pkg::DATA_W-1:0] m_axis_tdata,
   input  logic [pktbuf_pkg::NUM_QUEUES-1:0]                         m_axis_tlast,
   input  logic [pktbuf_pkg::NUM_QUEUES-1:0]                         m_axis_tvalid,
   input  logic [pktbuf_pkg::NUM_QUEUES-1:0]                         m_axis_tready,
   input  logic [pktbuf_pkg::NUM_QUEUES-1:0][pktbuf_pkg::WORD_W-1:0] exp_word,
   output int                                                        rx_cnt [pktbuf_pkg::NUM_QUEUES],
   output int                                                        error_count
);
   import pktbuf_pkg::*;

   logic                              rst_prev;
   logic [NUM_QUEUES-1:0]             stall_prev;   // valid without ready last cycle
   logic [NUM_QUEUES-1:0][DATA_W-1:0] data_prev;
   logic [NUM_QUEUES-1:0]             last_prev;

   initial
   begin
      rst_prev    = 1'b1;
      stall_prev  = '0;
      error_count = 0;
      for (int q = 0; q < NUM_QUEUES; q++)
         rx_cnt[q] = 0;
   end

   task automatic show_mismatch(input string name, input int q, input logic [63:0] got,
                                input logic [63:0] exp);
      $display("Error: %s[%0d] = %0h, expected %0h", name, q, got, exp);
      error_count++;
   endtask

   // negedge sampling, everything settled and the next edge decides the transfer
   always @(negedge clk)
   begin
      if (rst || rst_prev)
      begin
         if (m_axis_tvalid != '0)
            show_mismatch("m_axis_tvalid", 0, 64'(m_axis_tvalid), 64'(0));
         if (s_axis_tready != '1)
            show_mismatch("s_axis_tready", 0, 64'(s_axis_tready), 64'(4'hf));
      end
      for (int q = 0; q < NUM_QUEUES; q++)
      begin
         if (!rst && stall_prev[q])
         begin
            if (!m_axis_tvalid[q])
               show_mismatch("m_axis_tvalid", q, 64'(0), 64'(1));   // dropped before transfer
            if (m_axis_tdata[q] != data_prev[q])
               show_mismatch("m_axis_tdata", q, 64'(m_axis_tdata[q]), 64'(data_prev[q]));
            if (m_axis_tlast[q] != last_prev[q])
               show_mismatch("m_axis_tlast", q, 64'(m_axis_tlast[q]), 64'(last_prev[q]));
         end
         if (!rst && m_axis_tvalid[q] && m_axis_tready[q])
         begin
            if (rx_cnt[q] >= WORDS_PER_QUEUE)
            begin
               $display("queue %0d delivered more words than were sent", q);
               error_count++;
            end
            else
            begin
               if (m_axis_tdata[q][DATA_W-1 -: QID_W] != QID_W'(q))
                  show_mismatch("m_axis_tdata queue field", q,
                                64'(m_axis_tdata[q][DATA_W-1 -: QID_W]), 64'(q));
               if (m_axis_tdata[q] != exp_word[q][DATA_W-1:0])
                  show_mismatch("m_axis_tdata", q, 64'(m_axis_tdata[q]),
                                64'(exp_word[q][DATA_W-1:0]));
               if (m_axis_tlast[q] != exp_word[q][DATA_W])
                  show_mismatch("m_axis_tlast", q, 64'(m_axis_tlast[q]),
                                64'(exp_word[q][DATA_W]));
            end
            rx_cnt[q]++;
         end
         stall_prev[q] = !rst && m_axis_tvalid[q] && !m_axis_tready[q];
         data_prev[q]  = m_axis_tdata[q];
         last_prev[q]  = m_axis_tlast[q];
      end
      rst_prev = rst;
   end

endmodule

// File: src/pktbuf_top.sv
module pktbuf_top (
   input  logic                                                     intClk,
   input  logic                                                     rst,
   input  logic [pktbuf_pkg::NUM_QUEUES-1:0][pktbuf_pkg::DATA_W-1:0] s_axis_tdata,
   input  logic [pktbuf_pkg::NUM_QUEUES-1:0]                        s_axis_tlast,
   input  logic [pktbuf_pkg::NUM_QUEUES-1:0]                        s_axis_tvalid,
   output logic [pktbuf_pkg::NUM_QUEUES-1:0]                        s_axis_tready,
   output logic [pktbuf_pkg::NUM_QUEUES-1:0][pktbuf_pkg::DATA_W-1:0] m_axis_tdata,
   output logic [pktbuf_pkg::NUM_QUEUES-1:0]                        m_axis_tlast,
   output logic [pktbuf_pkg::NUM_QUEUES-1:0]                        m_axis_tvalid,
   input  logic [pktbuf_pkg::NUM_QUEUES-1:0]                        m_axis_tready
);
   import pktbuf_pkg::*;

   logic [NUM_QUEUES-1:0]              src_valid;
   logic [NUM_QUEUES-1:0][WORD_W-1:0]  src_word;
   logic [NUM_QUEUES-1:0]              src_ready;
   logic [NUM_QUEUES-1:0]              dst_valid;
   logic [NUM_QUEUES-1:0][WORD_W-1:0]  dst_word;
   logic [NUM_QUEUES-1:0]              dst_pop;
   logic [NUM_QUEUES-1:0][WORD_W-1:0]  out_word;

   qwrite_if wr_bus ();
   qread_if  rd_bus ();

   assign dst_pop = m_axis_tvalid & m_axis_tready;   // each delivered word frees a credit

   for (genvar g = 0; g < NUM_QUEUES; g++)
   begin : g_queue
      // input side, stored word is {tlast, tdata}
      word_fifo #(.DEPTH(IN_FIFO_DEPTH)) i_in_fifo (
         .clk       (intClk),
         .rst       (rst),
         .in_valid  (s_axis_tvalid[g]),
         .in_ready  (s_axis_tready[g]),
         .in_word   ({s_axis_tlast[g], s_axis_tdata[g]}),
         .out_valid (src_valid[g]),
         .out_ready (src_ready[g]),
         .out_word  (src_word[g])
      );

      // credits keep this one from overflowing
      word_fifo #(.DEPTH(OUT_FIFO_DEPTH)) i_out_fifo (
         .clk       (intClk),
         .rst       (rst),
         .in_valid  (dst_valid[g]),
         .in_ready  (),
         .in_word   (dst_word[g]),
         .out_valid (m_axis_tvalid[g]),
         .out_ready (m_axis_tready[g]),
         .out_word  (out_word[g])
      );

      assign m_axis_tdata[g] = out_word[g][DATA_W-1:0];
      assign m_axis_tlast[g] = out_word[g][DATA_W];
   end

   in_arbiter i_in_arb (
      .clk       (intClk),
      .rst       (rst),
      .src_valid (src_valid),
      .src_word  (src_word),
      .src_ready (src_ready),
      .wr        (wr_bus.arb)
   );

   queue_mem i_mem (
      .clk (intClk),
      .rst (rst),
      .wr  (wr_bus.mem),
      .rd  (rd_bus.mem)
   );

   out_arbiter i_out_arb (
      .clk       (intClk),
      .rst       (rst),
      .rd        (rd_bus.arb),
      .dst_valid (dst_valid),
      .dst_word  (dst_word),
      .dst_pop   (dst_pop)
   );

endmodule

// File: src/out_arbiter.sv
module out_arbiter (
   input  logic                                                     clk,
   input  logic                                                     rst,
   qread_if.arb                                                     rd,
   output logic [pktbuf_pkg::NUM_QUEUES-1:0]                        dst_valid,
   output logic [pktbuf_pkg::NUM_QUEUES-1:0][pktbuf_pkg::WORD_W-1:0] dst_word,
   input  logic [pktbuf_pkg::NUM_QUEUES-1:0]                        dst_pop
);
   import pktbuf_pkg::*;

   // free output FIFO slots minus reads in flight
   logic [NUM_QUEUES-1:0][CREDIT_W-1:0] credit;
   logic [NUM_QUEUES-1:0]               eligible;
   logic [NUM_QUEUES-1:0]               take;
   logic [QID_W-1:0]                    ptr;
   logic [QID_W-1:0]                    cand;
   logic [QID_W-1:0]                    grant_qid;
   logic                                grant_hit;

   always_comb
   begin
      for (int q = 0; q < NUM_QUEUES; q++)
         eligible[q] = !rd.empty[q] && (credit[q] != '0);
      grant_hit = 1'b0;
      grant_qid = ptr;
      cand      = ptr;
      for (int i = 0; i < NUM_QUEUES; i++)
      begin
         cand = ptr + QID_W'(i);
         if (!grant_hit && eligible[cand])
         begin
            grant_hit = 1'b1;
            grant_qid = cand;
         end
      end
      for (int q = 0; q < NUM_QUEUES; q++)
      begin
         take[q]      = grant_hit && (grant_qid == QID_W'(q));
         dst_valid[q] = rd.rd_valid && (rd.rd_qid == QID_W'(q));   // steer by returned qid
         dst_word[q]  = rd.rd_word;
      end
   end

   assign rd.req     = grant_hit;
   assign rd.req_qid = grant_qid;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ptr <= '0;
         for (int q = 0; q < NUM_QUEUES; q++)
            credit[q] <= CREDIT_W'(OUT_FIFO_DEPTH);   // output FIFOs start empty
      end
      else
      begin
         if (grant_hit)
            ptr <= grant_qid + 1'b1;
         for (int q = 0; q < NUM_QUEUES; q++)
         begin
            if (take[q] && !dst_pop[q])
               credit[q] <= credit[q] - 1'b1;
            else if (dst_pop[q] && !take[q])
               credit[q] <= credit[q] + 1'b1;
         end
      end
   end

   // a wrapped counter reads above the start value
   for (genvar g = 0; g < NUM_QUEUES; g++)
   begin : g_credit_chk
      a_credit_range: assert property (@(posedge clk) disable iff (rst)
         credit[g] <= CREDIT_W'(OUT_FIFO_DEPTH));
   end

endmodule

// File: src/queue_mem.sv
module queue_mem (
   input  logic  clk,
   input  logic  rst,
   qwrite_if.mem wr,
   qread_if.mem  rd
);
   import pktbuf_pkg::*;

   logic [WORD_W-1:0] mem [NUM_QUEUES*QUEUE_DEPTH];

   logic [NUM_QUEUES-1:0][QADDR_W-1:0] head;   // next read offset
   logic [NUM_QUEUES-1:0][QADDR_W-1:0] tail;   // next write offset
   logic [NUM_QUEUES-1:0][QADDR_W:0]   count;
   logic [NUM_QUEUES-1:0][QADDR_W:0]   count_nxt;
   logic [NUM_QUEUES-1:0]              wr_hit;
   logic [NUM_QUEUES-1:0]              rd_hit;
   logic [NUM_QUEUES-1:0]              full_q;
   logic [NUM_QUEUES-1:0]              empty_q;

   //////////////////////////////
   // occupancy per queue
   //////////////////////////////

   always_comb
   begin
      for (int q = 0; q < NUM_QUEUES; q++)
      begin
         wr_hit[q]    = wr.valid && (wr.qid == QID_W'(q));
         rd_hit[q]    = rd.req && (rd.req_qid == QID_W'(q));
         count_nxt[q] = count[q];
         if (wr_hit[q] && !rd_hit[q])
            count_nxt[q] = count[q] + 1'b1;
         else if (rd_hit[q] && !wr_hit[q])
            count_nxt[q] = count[q] - 1'b1;
      end
   end

   assign wr.full  = full_q;
   assign rd.empty = empty_q;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         head        <= '0;
         tail        <= '0;
         count       <= '0;
         full_q      <= '0;
         empty_q     <= '1;
         rd.rd_valid <= 1'b0;
      end
      else
      begin
         if (wr.valid)
            tail[wr.qid] <= tail[wr.qid] + 1'b1;         // wraps inside the region
         if (rd.req)
            head[rd.req_qid] <= head[rd.req_qid] + 1'b1;
         count       <= count_nxt;
         rd.rd_valid <= rd.req;
         for (int q = 0; q < NUM_QUEUES; q++)
         begin
            full_q[q]  <= (count_nxt[q] == (QADDR_W + 1)'(QUEUE_DEPTH));
            empty_q[q] <= (count_nxt[q] == '0);
         end
      end
   end

   // head and tail never meet while a read and a write are both legal
   always_ff @(posedge clk)
   begin
      if (wr.valid)
         mem[{wr.qid, tail[wr.qid]}] <= wr.word;
      if (rd.req)
      begin
         rd.rd_word <= mem[{rd.req_qid, head[rd.req_qid]}];
         rd.rd_qid  <= rd.req_qid;
      end
   end

   a_no_write_full: assert property (@(posedge clk) disable iff (rst)
      wr.valid |-> !wr.full[wr.qid]);
   a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
      rd.req |-> !rd.empty[rd.req_qid]);

endmodule

// File: src/in_arbiter.sv
module in_arbiter (
   input  logic                                                     clk,
   input  logic                                                     rst,
   input  logic [pktbuf_pkg::NUM_QUEUES-1:0]                        src_valid,
   input  logic [pktbuf_pkg::NUM_QUEUES-1:0][pktbuf_pkg::WORD_W-1:0] src_word,
   output logic [pktbuf_pkg::NUM_QUEUES-1:0]                        src_ready,
   qwrite_if.arb                                                    wr
);
   import pktbuf_pkg::*;

   logic [NUM_QUEUES-1:0] eligible;
   logic [QID_W-1:0]      ptr;        // queue with top priority
   logic [QID_W-1:0]      cand;
   logic [QID_W-1:0]      grant_qid;
   logic                  grant_hit;

   // a queue may go only if its region has room
   assign eligible = src_valid & ~wr.full;

   always_comb
   begin
      grant_hit = 1'b0;
      grant_qid = ptr;
      cand      = ptr;
      for (int i = 0; i < NUM_QUEUES; i++)
      begin
         cand = ptr + QID_W'(i);   // wraps around the queue count
         if (!grant_hit && eligible[cand])
         begin
            grant_hit = 1'b1;
            grant_qid = cand;
         end
      end
      src_ready = '0;
      if (grant_hit)
         src_ready[grant_qid] = 1'b1;   // pops the FIFO on this edge
   end

   // write lands at the same edge as the pop
   assign wr.valid = grant_hit;
   assign wr.qid   = grant_qid;
   assign wr.word  = src_word[grant_qid];

   always_ff @(posedge clk)
   begin
      if (rst)
         ptr <= '0;
      else if (grant_hit)
         ptr <= grant_qid + 1'b1;   // skip past the winner
   end

endmodule

// File: src/word_fifo.sv
module word_fifo #(
   parameter int DEPTH = 4
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          in_valid,
   output logic                          in_ready,
   input  logic [pktbuf_pkg::WORD_W-1:0] in_word,
   output logic                          out_valid,
   input  logic                          out_ready,
   output logic [pktbuf_pkg::WORD_W-1:0] out_word
);
   import pktbuf_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WORD_W-1:0] mem [DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;
   logic              push;
   logic              pop;

   assign in_ready  = (count != CNT_W'(DEPTH));
   assign out_valid = (count != '0);
   assign out_word  = mem[rd_ptr];   // head word shown directly
   assign push      = in_valid & in_ready;
   assign pop       = out_valid & out_ready;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= in_word;
   end

   // pointers meet only when the FIFO is empty or full
   a_ptr_count: assert property (@(posedge clk) disable iff (rst)
      (wr_ptr == rd_ptr) == ((count == '0) || (count == CNT_W'(DEPTH))));

endmodule

// File: src/qbuf_if.sv
// write side, input arbiter into the shared memory
interface qwrite_if;
   import pktbuf_pkg::*;

   logic                  valid;   // one word written per cycle
   logic [QID_W-1:0]      qid;
   logic [WORD_W-1:0]     word;
   logic [NUM_QUEUES-1:0] full;    // per queue region

   modport arb (output valid, output qid, output word, input full);
   modport mem (input valid, input qid, input word, output full);

endinterface

// read side, data comes back one cycle after req
interface qread_if;
   import pktbuf_pkg::*;

   logic                  req;
   logic [QID_W-1:0]      req_qid;
   logic                  rd_valid;
   logic [QID_W-1:0]      rd_qid;
   logic [WORD_W-1:0]     rd_word;
   logic [NUM_QUEUES-1:0] empty;

   modport arb (
      output req, output req_qid,
      input rd_valid, input rd_qid, input rd_word, input empty
   );
   modport mem (
      input req, input req_qid,
      output rd_valid, output rd_qid, output rd_word, output empty
   );

endinterface

// File: src/pktbuf_pkg.sv
package pktbuf_pkg;

   //////////////////////////////
   // stream layout
   //////////////////////////////

   localparam int NUM_QUEUES = 4;
   localparam int QID_W      = 2;           // log2 of NUM_QUEUES
   localparam int DATA_W     = 32;          // tdata
   localparam int WORD_W     = DATA_W + 1;  // tlast sits above tdata

   //////////////////////////////
   // buffering
   //////////////////////////////

   localparam int IN_FIFO_DEPTH  = 4;
   localparam int OUT_FIFO_DEPTH = 4;   // also the reset credit per queue

   // each queue owns one circular region of the shared memory
   localparam int QUEUE_DEPTH = 16;
   localparam int QADDR_W     = 4;      // region offset, wraps naturally

   // holds 0 .. OUT_FIFO_DEPTH
   localparam int CREDIT_W = 3;

endpackage
